//--- vlog.f
+incdir+src
+incdir+tests
src/tunnel_pkg.sv
src/raster_scan.sv
src/frame_geometry.sv
src/score_glyph.sv
src/color_select.sv
src/tunnel_display.sv
tests/tunnel_display_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tunnel_display_tb -o tunnel_sim

./obj_dir/tunnel_sim | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- tests/tunnel_ref.svh
// reference playfield model
`ifndef TUNNEL_REF_SVH
`define TUNNEL_REF_SVH

`include "tunnel_macros.svh"

function automatic bit outline_hit(int x, int y, int fx, int fy, int fw, int fh);
	bit rows;
	bit cols;
	rows = (y == fy || y == fy + fh - 1) && x >= fx && x < fx + fw;
	cols = (x == fx || x == fx + fw - 1) && y >= fy && y < fy + fh;
	return rows || cols;
endfunction

function automatic bit ref_frame_hit(int x, int y);
	return outline_hit(x, y, `FRAME_0_X, `FRAME_0_Y, `FRAME_0_W, `FRAME_0_H)
		|| outline_hit(x, y, `FRAME_1_X, `FRAME_1_Y, `FRAME_1_W, `FRAME_1_H)
		|| outline_hit(x, y, `FRAME_2_X, `FRAME_2_Y, `FRAME_2_W, `FRAME_2_H)
		|| outline_hit(x, y, `FRAME_3_X, `FRAME_3_Y, `FRAME_3_W, `FRAME_3_H)
		|| outline_hit(x, y, `FRAME_4_X, `FRAME_4_Y, `FRAME_4_W, `FRAME_4_H)
		|| outline_hit(x, y, `FRAME_5_X, `FRAME_5_Y, `FRAME_5_W, `FRAME_5_H)
		|| outline_hit(x, y, `FRAME_6_X, `FRAME_6_Y, `FRAME_6_W, `FRAME_6_H)
		|| outline_hit(x, y, `FRAME_7_X, `FRAME_7_Y, `FRAME_7_W, `FRAME_7_H)
		|| outline_hit(x, y, `FRAME_8_X, `FRAME_8_Y, `FRAME_8_W, `FRAME_8_H);
endfunction

// row r below the first row starts 4*(r/3) + r%3 away, 3 wide when r%3 is 2
function automatic bit diag_band(int x, int y, int x1, int y1, int x2, int y2);
	int r;
	int shift;
	int width;
	int lo;
	int hi;
	if (y < y1 || y > y2)
		return 1'b0;
	r = y - y1;
	shift = 4 * (r / 3) + r % 3;
	width = (r % 3 == 2) ? 3 : 2;
	if (x2 > x1) begin
		lo = x1 + shift;
		hi = (lo + width - 1 > x2) ? x2 : lo + width - 1;
	end else begin
		hi = x1 - shift;
		lo = (hi - width + 1 < x2) ? x2 : hi - width + 1;
	end
	return x >= lo && x <= hi;
endfunction

function automatic bit ref_diag_hit(int x, int y);
	return diag_band(x, y, `DIAG_0_X1, `DIAG_0_Y1, `DIAG_0_X2, `DIAG_0_Y2)
		|| diag_band(x, y, `DIAG_1_X1, `DIAG_1_Y1, `DIAG_1_X2, `DIAG_1_Y2)
		|| diag_band(x, y, `DIAG_2_X1, `DIAG_2_Y1, `DIAG_2_X2, `DIAG_2_Y2)
		|| diag_band(x, y, `DIAG_3_X1, `DIAG_3_Y1, `DIAG_3_X2, `DIAG_3_Y2);
endfunction

// bit 0 is segment a through bit 6 for g
function automatic bit [6:0] ref_segments(int d);
	bit [6:0] s;
	s = '0;
	if (d >= 0 && d <= 9) begin
		s[0] = d != 1 && d != 4;
		s[1] = d != 5 && d != 6;
		s[2] = d != 2;
		s[3] = d != 1 && d != 4 && d != 7;
		s[4] = d == 0 || d == 2 || d == 6 || d == 8;
		s[5] = d != 1 && d != 2 && d != 3 && d != 7;
		s[6] = d != 0 && d != 1 && d != 7;
	end
	return s;
endfunction

function automatic bit cell_lit(int cx, int cy, int digit);
	bit [6:0] s;
	bit wide;
	bit left;
	bit right;
	s = ref_segments(digit);
	wide = cx >= 6 && cx <= 25;
	left = cx >= 6 && cx <= 9;
	right = cx >= 22 && cx <= 25;
	return (s[0] && wide && cy >= 2 && cy <= 5)
		|| (s[1] && right && cy >= 2 && cy <= 17)
		|| (s[2] && right && cy >= 14 && cy <= 29)
		|| (s[3] && wide && cy >= 26 && cy <= 29)
		|| (s[4] && left && cy >= 14 && cy <= 29)
		|| (s[5] && left && cy >= 2 && cy <= 17)
		|| (s[6] && wide && cy >= 14 && cy <= 17);
endfunction

function automatic bit in_score_cell(int x, int y);
	return y >= `SCORE_Y && y < `SCORE_Y + `SCORE_CELL
		&& ((x >= `SCORE_L_X && x < `SCORE_L_X + `SCORE_CELL)
		|| (x >= `SCORE_R_X && x < `SCORE_R_X + `SCORE_CELL));
endfunction

function automatic bit ref_score_hit(int x, int y, int your, int their);
	if (!in_score_cell(x, y))
		return 1'b0;
	if (x < `SCORE_R_X)
		return cell_lit(x - `SCORE_L_X, y - `SCORE_Y, your);
	return cell_lit(x - `SCORE_R_X, y - `SCORE_Y, their);
endfunction

// green covers teal where they meet
function automatic logic [23:0] ref_color(int x, int y, int your, int their);
	if (ref_frame_hit(x, y) || ref_diag_hit(x, y))
		return `COLOR_FRAME;
	if (ref_score_hit(x, y, your, their))
		return `COLOR_SCORE;
	return `COLOR_BG;
endfunction

function automatic bit near_outline(int x, int y);
	return ref_frame_hit(x, y) || ref_frame_hit(x - 1, y) || ref_frame_hit(x + 1, y)
		|| ref_frame_hit(x, y - 1) || ref_frame_hit(x, y + 1);
endfunction

function automatic bit in_diag_box(int x, int y);
	return (y >= `DIAG_0_Y1 && y <= `DIAG_0_Y2 && x >= `DIAG_0_X1 && x <= `DIAG_0_X2)
		|| (y >= `DIAG_1_Y1 && y <= `DIAG_1_Y2 && x >= `DIAG_1_X1 && x <= `DIAG_1_X2)
		|| (y >= `DIAG_2_Y1 && y <= `DIAG_2_Y2 && x >= `DIAG_2_X2 && x <= `DIAG_2_X1)
		|| (y >= `DIAG_3_Y1 && y <= `DIAG_3_Y2 && x >= `DIAG_3_X2 && x <= `DIAG_3_X1);
endfunction

`endif

//--- tests/tunnel_display_tb.sv
// tunnel display testbench
`default_nettype none
`include "tunnel_macros.svh"

module tunnel_display_tb import tunnel_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	`include "tunnel_ref.svh"

	localparam int FRAME_PIXELS = `H_ACTIVE * `V_ACTIVE;
	localparam int NUM_FRAMES   = 3;
	// 3 frames, doubled for stalls, plus margin
	localparam int TIMEOUT_CYCLES = 2000000;

	// scores shown in frames 0, 1 and 2
	localparam logic [3:0] YOUR_SEQ [3]  = '{4'd3, 4'd8, 4'd13};
	localparam logic [3:0] THEIR_SEQ [3] = '{4'd7, 4'd12, 4'd0};

	logic       clk;
	logic       rst;
	logic [3:0] your_score;
	logic [3:0] their_score;
	out_pixel_t pixel;
	logic       pix_valid;
	logic       pix_ready;

	int         checks [1:6] = '{default: 0};
	int         errors [1:6] = '{default: 0};
	string      test_name [1:6] = '{"reset and first beat", "scan order and stall",
		"frame outlines", "diagonal bands", "score digits", "full frame colour"};
	int         cycle_count = 0;
	int         edges = 0;
	int         pixels_done = 0;
	int         exp_x = 0;
	int         exp_y = 0;
	int         frame = 0;
	int         exp_your = 0;
	int         exp_their = 0;
	bit         seen_first = 1'b0;
	bit         stalled = 1'b0;
	bit         score_change = 1'b0;
	out_pixel_t held;

	tunnel_display tunnel_display_i (
		.clk         (clk),
		.rst         (rst),
		.your_score  (your_score),
		.their_score (their_score),
		.pixel       (pixel),
		.pix_valid   (pix_valid),
		.pix_ready   (pix_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d cycles with %0d pixels received",
				cycle_count, pixels_done);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic report_test(int n);
		$display("test %0d %s: %0d checks, %0d errors", n, test_name[n], checks[n], errors[n]);
	endtask

	// first frame runs unstalled, then ready is high 3 times in 4
	task automatic drive_inputs();
		pix_ready = (frame == 0) ? 1'b1 : (($urandom % 4) != 0);
		if (score_change && frame + 1 < NUM_FRAMES) begin
			your_score  = YOUR_SEQ[frame + 1];
			their_score = THEIR_SEQ[frame + 1];
		end
		score_change = 1'b0;
	endtask

	task automatic check_color(int n, logic [23:0] want, bit greens_only);
		bit ok;
		ok = greens_only ? ((pixel.color == `COLOR_FRAME) == (want == `COLOR_FRAME))
			: (pixel.color == want);
		checks[n]++;
		assert (ok) else begin
			$display("[FAIL] pixel.color got %h expected %h at (%0d,%0d) in frame %0d",
				pixel.color, want, exp_x, exp_y, frame);
			errors[n]++;
		end
	endtask

	task automatic check_transfer();
		logic [23:0] want;
		// the DUT latched scores as this pixel entered the score stage
		if (exp_x == 0 && exp_y == 0) begin
			exp_your  = int'(your_score);
			exp_their = int'(their_score);
		end
		checks[2]++;
		assert (pixel.pos.x == 10'(exp_x) && pixel.pos.y == 10'(exp_y)) else begin
			$display("[FAIL] pixel.pos got %h,%h expected %h,%h",
				pixel.pos.x, pixel.pos.y, exp_x, exp_y);
			errors[2]++;
		end
		checks[2]++;
		assert (pixel.pos.line_end == (exp_x == `H_ACTIVE - 1)
				&& pixel.pos.frame_start == (exp_x == 0 && exp_y == 0)) else begin
			$display("[FAIL] pixel.pos flags got %h,%h expected %h,%h at (%0d,%0d)",
				pixel.pos.line_end, pixel.pos.frame_start, exp_x == `H_ACTIVE - 1,
				exp_x == 0 && exp_y == 0, exp_x, exp_y);
			errors[2]++;
		end
		want = ref_color(exp_x, exp_y, exp_your, exp_their);
		if (near_outline(exp_x, exp_y))
			check_color(3, want, 1'b1);
		if (in_diag_box(exp_x, exp_y))
			check_color(4, want, 1'b1);
		if (in_score_cell(exp_x, exp_y))
			check_color(5, want, 1'b0);
		check_color(6, want, 1'b0);
		// changed before the digit rows, shown only from the next frame
		if (exp_x == 0 && exp_y == 5)
			score_change = 1'b1;
		pixels_done++;
		if (exp_x == `H_ACTIVE - 1) begin
			exp_x = 0;
			if (exp_y == `V_ACTIVE - 1) begin
				exp_y = 0;
				frame++;
			end else begin
				exp_y++;
			end
		end else begin
			exp_x++;
		end
	endtask

	task automatic sample_outputs();
		if (stalled) begin
			checks[2]++;
			assert (pix_valid) else begin
				$display("pix_valid dropped while the sink was stalling");
				errors[2]++;
			end
			checks[2]++;
			assert (pixel == held) else begin
				$display("[FAIL] pixel got %h expected %h while stalled", pixel, held);
				errors[2]++;
			end
		end
		if (pix_valid && !seen_first) begin
			seen_first = 1'b1;
			// source valid on the first edge, then three stage registers
			checks[1]++;
			assert (edges == 4) else begin
				$display("[FAIL] pix_valid latency got %h expected %h", edges, 4);
				errors[1]++;
			end
			checks[1]++;
			assert (pixel.pos.x == 10'd0 && pixel.pos.y == 10'd0) else begin
				$display("[FAIL] pixel.pos first beat got %h,%h expected 0,0",
					pixel.pos.x, pixel.pos.y);
				errors[1]++;
			end
			report_test(1);
		end
		stalled = pix_valid && !pix_ready;
		held = pixel;
		if (pix_valid && pix_ready)
			check_transfer();
	endtask

	initial begin
		int seed_ret;
		int total_checks;
		int total_errors;
		seed_ret = $urandom(58326);
		rst = 1'b1;
		pix_ready = 1'b1;
		your_score = YOUR_SEQ[0];
		their_score = THEIR_SEQ[0];
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#1;
			checks[1]++;
			assert (pix_valid === 1'b0) else begin
				$display("[FAIL] pix_valid got %h expected 0 during reset", pix_valid);
				errors[1]++;
			end
		end
		rst = 1'b0;
		while (pixels_done < NUM_FRAMES * FRAME_PIXELS) begin
			@(posedge clk);
			edges++;
			#1;
			drive_inputs();
			@(negedge clk);
			sample_outputs();
		end
		total_checks = 0;
		total_errors = 0;
		for (int n = 1; n <= 6; n++) begin
			if (n > 1)
				report_test(n);
			total_checks += checks[n];
			total_errors += errors[n];
		end
		$display("tests 6, checks %0d, errors %0d", total_checks, total_errors);
		if (total_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/tunnel_display.sv
// tunnel playfield display top
`default_nettype none

module tunnel_display import tunnel_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [3:0] your_score,
	input  logic [3:0] their_score,
	output out_pixel_t pixel,
	output logic       pix_valid,
	input  logic       pix_ready
);

	pixel_pos_t  pos;
	logic        pos_valid;
	logic        pos_ready;
	geom_beat_t  geom;
	logic        geom_valid;
	logic        geom_ready;
	score_beat_t score;
	logic        score_valid;
	logic        score_ready;

	raster_scan u_scan (
		.clk       (clk),
		.rst       (rst),
		.pos       (pos),
		.pos_valid (pos_valid),
		.pos_ready (pos_ready)
	);

	frame_geometry u_geom (
		.clk       (clk),
		.rst       (rst),
		.in_pos    (pos),
		.in_valid  (pos_valid),
		.in_ready  (pos_ready),
		.out_beat  (geom),
		.out_valid (geom_valid),
		.out_ready (geom_ready)
	);

	score_glyph u_score (
		.clk         (clk),
		.rst         (rst),
		.your_score  (your_score),
		.their_score (their_score),
		.in_beat     (geom),
		.in_valid    (geom_valid),
		.in_ready    (geom_ready),
		.out_beat    (score),
		.out_valid   (score_valid),
		.out_ready   (score_ready)
	);

	color_select u_color (
		.clk       (clk),
		.rst       (rst),
		.in_beat   (score),
		.in_valid  (score_valid),
		.in_ready  (score_ready),
		.pixel     (pixel),
		.pix_valid (pix_valid),
		.pix_ready (pix_ready)
	);

endmodule

`default_nettype wire

//--- src/color_select.sv
// pixel colour stage
`default_nettype none
`include "tunnel_macros.svh"

module color_select import tunnel_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  score_beat_t in_beat,
	input  logic        in_valid,
	output logic        in_ready,
	output out_pixel_t  pixel,
	output logic        pix_valid,
	input  logic        pix_ready
);

	logic [23:0] color;
	logic        take;

	assign in_ready = !pix_valid || pix_ready;
	assign take     = in_valid && in_ready;

	// green wins over teal
	always_comb begin
		if (in_beat.geom.frame_hit || in_beat.geom.diag_hit)
			color = `COLOR_FRAME;
		else if (in_beat.score_hit)
			color = `COLOR_SCORE;
		else
			color = `COLOR_BG;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pix_valid <= 1'b0;
		else if (in_ready)
			pix_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pixel.pos   <= in_beat.geom.pos;
			pixel.color <= color;
		end
	end

endmodule

`default_nettype wire

//--- src/score_glyph.sv
// seven-segment score stage
`default_nettype none
`include "tunnel_macros.svh"

module score_glyph import tunnel_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic [3:0]  your_score,
	input  logic [3:0]  their_score,
	input  geom_beat_t  in_beat,
	input  logic        in_valid,
	output logic        in_ready,
	output score_beat_t out_beat,
	output logic        out_valid,
	input  logic        out_ready
);

	localparam logic [9:0] L_X  = `SCORE_L_X;
	localparam logic [9:0] R_X  = `SCORE_R_X;
	localparam logic [9:0] TOP  = `SCORE_Y;
	localparam logic [9:0] CELL = `SCORE_CELL;

	logic [3:0] your_q;
	logic [3:0] their_q;
	logic       take;
	logic       in_left;
	logic       in_right;
	logic       in_rows;
	logic [9:0] cx_full;
	logic [9:0] cy_full;
	logic [4:0] cx;
	logic [4:0] cy;
	logic [6:0] segs;
	logic       lit;
	logic       score_hit;

	// segments {g,f,e,d,c,b,a} with blank above 9
	function automatic logic [6:0] seg7(input logic [3:0] d);
		case (d)
			4'd0:    seg7 = 7'b0111111;
			4'd1:    seg7 = 7'b0000110;
			4'd2:    seg7 = 7'b1011011;
			4'd3:    seg7 = 7'b1001111;
			4'd4:    seg7 = 7'b1100110;
			4'd5:    seg7 = 7'b1101101;
			4'd6:    seg7 = 7'b1111101;
			4'd7:    seg7 = 7'b0000111;
			4'd8:    seg7 = 7'b1111111;
			4'd9:    seg7 = 7'b1101111;
			default: seg7 = 7'b0000000;
		endcase
	endfunction

	assign in_ready = !out_valid || out_ready;
	assign take     = in_valid && in_ready;

	// scores only change at a frame boundary
	always_ff @(posedge clk) begin
		if (take && in_beat.pos.frame_start) begin
			your_q  <= your_score;
			their_q <= their_score;
		end
	end

	assign in_left  = in_beat.pos.x >= L_X && in_beat.pos.x < L_X + CELL;
	assign in_right = in_beat.pos.x >= R_X && in_beat.pos.x < R_X + CELL;
	assign in_rows  = in_beat.pos.y >= TOP && in_beat.pos.y < TOP + CELL;

	// offsets inside the 32x32 cell
	assign cx_full = in_beat.pos.x - (in_left ? L_X : R_X);
	assign cy_full = in_beat.pos.y - TOP;
	assign cx      = cx_full[4:0];
	assign cy      = cy_full[4:0];
	assign segs    = seg7(in_left ? your_q : their_q);

	always_comb begin
		logic span_x;
		logic col_l;
		logic col_r;
		logic upper;
		logic lower;
		span_x = cx >= 5'd6 && cx <= 5'd25;
		col_l  = cx >= 5'd6 && cx <= 5'd9;
		col_r  = cx >= 5'd22 && cx <= 5'd25;
		upper  = cy >= 5'd2 && cy <= 5'd17;
		lower  = cy >= 5'd14 && cy <= 5'd29;
		lit = (segs[0] && span_x && cy >= 5'd2 && cy <= 5'd5)
			|| (segs[1] && col_r && upper)
			|| (segs[2] && col_r && lower)
			|| (segs[3] && span_x && cy >= 5'd26 && cy <= 5'd29)
			|| (segs[4] && col_l && lower)
			|| (segs[5] && col_l && upper)
			|| (segs[6] && span_x && cy >= 5'd14 && cy <= 5'd17);
	end

	assign score_hit = in_rows && (in_left || in_right) && lit;

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_beat.geom      <= in_beat;
			out_beat.score_hit <= score_hit;
		end
	end

endmodule

`default_nettype wire

//--- src/frame_geometry.sv
// rectangle and diagonal hit stage
`default_nettype none
`include "tunnel_macros.svh"

module frame_geometry import tunnel_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  pixel_pos_t in_pos,
	input  logic       in_valid,
	output logic       in_ready,
	output geom_beat_t out_beat,
	output logic       out_valid,
	input  logic       out_ready
);

	localparam logic [9:0] FRAME_X [9] = '{`FRAME_0_X, `FRAME_1_X, `FRAME_2_X, `FRAME_3_X,
		`FRAME_4_X, `FRAME_5_X, `FRAME_6_X, `FRAME_7_X, `FRAME_8_X};
	localparam logic [9:0] FRAME_Y [9] = '{`FRAME_0_Y, `FRAME_1_Y, `FRAME_2_Y, `FRAME_3_Y,
		`FRAME_4_Y, `FRAME_5_Y, `FRAME_6_Y, `FRAME_7_Y, `FRAME_8_Y};
	localparam logic [9:0] FRAME_W [9] = '{`FRAME_0_W, `FRAME_1_W, `FRAME_2_W, `FRAME_3_W,
		`FRAME_4_W, `FRAME_5_W, `FRAME_6_W, `FRAME_7_W, `FRAME_8_W};
	localparam logic [9:0] FRAME_H [9] = '{`FRAME_0_H, `FRAME_1_H, `FRAME_2_H, `FRAME_3_H,
		`FRAME_4_H, `FRAME_5_H, `FRAME_6_H, `FRAME_7_H, `FRAME_8_H};

	localparam logic [9:0] DIAG_X1 [4] = '{`DIAG_0_X1, `DIAG_1_X1, `DIAG_2_X1, `DIAG_3_X1};
	localparam logic [9:0] DIAG_Y1 [4] = '{`DIAG_0_Y1, `DIAG_1_Y1, `DIAG_2_Y1, `DIAG_3_Y1};
	localparam logic [9:0] DIAG_X2 [4] = '{`DIAG_0_X2, `DIAG_1_X2, `DIAG_2_X2, `DIAG_3_X2};
	localparam logic [9:0] DIAG_Y2 [4] = '{`DIAG_0_Y2, `DIAG_1_Y2, `DIAG_2_Y2, `DIAG_3_Y2};

	logic [9:0] x_start [4];
	logic [1:0] cnt3 [4];
	logic       frame_hit;
	logic       diag_hit;
	logic       take;

	assign in_ready = !out_valid || out_ready;
	assign take     = in_valid && in_ready;

	// outline is top and bottom rows plus left and right columns
	always_comb begin
		frame_hit = 1'b0;
		for (int i = 0; i < 9; i++) begin
			if ((in_pos.y == FRAME_Y[i] || in_pos.y == FRAME_Y[i] + FRAME_H[i] - 10'd1)
					&& in_pos.x >= FRAME_X[i] && in_pos.x < FRAME_X[i] + FRAME_W[i])
				frame_hit = 1'b1;
			if ((in_pos.x == FRAME_X[i] || in_pos.x == FRAME_X[i] + FRAME_W[i] - 10'd1)
					&& in_pos.y >= FRAME_Y[i] && in_pos.y < FRAME_Y[i] + FRAME_H[i])
				frame_hit = 1'b1;
		end
	end

	// trackers step once per transferred line end
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 4; i++) begin
				x_start[i] <= DIAG_X1[i];
				cnt3[i]    <= 2'd0;
			end
		end else if (take && in_pos.line_end) begin
			for (int i = 0; i < 4; i++) begin
				if (in_pos.y + 10'd1 == DIAG_Y1[i]) begin
					x_start[i] <= DIAG_X1[i];
					cnt3[i]    <= 2'd0;
				end else if (in_pos.y >= DIAG_Y1[i] && in_pos.y <= DIAG_Y2[i]) begin
					if (cnt3[i] == 2'd2) begin
						cnt3[i]    <= 2'd0;
						x_start[i] <= (DIAG_X2[i] > DIAG_X1[i]) ? x_start[i] + 10'd2
							: x_start[i] - 10'd2;
					end else begin
						cnt3[i]    <= cnt3[i] + 2'd1;
						x_start[i] <= (DIAG_X2[i] > DIAG_X1[i]) ? x_start[i] + 10'd1
							: x_start[i] - 10'd1;
					end
				end
			end
		end
	end

	// band is 2 wide, 3 on the row before a double step
	always_comb begin
		logic       in_box;
		logic       band;
		logic [9:0] span;
		diag_hit = 1'b0;
		for (int i = 0; i < 4; i++) begin
			span   = (cnt3[i] == 2'd2) ? 10'd2 : 10'd1;
			in_box = in_pos.y >= DIAG_Y1[i] && in_pos.y <= DIAG_Y2[i]
				&& in_pos.x >= ((DIAG_X2[i] > DIAG_X1[i]) ? DIAG_X1[i] : DIAG_X2[i])
				&& in_pos.x <= ((DIAG_X2[i] > DIAG_X1[i]) ? DIAG_X2[i] : DIAG_X1[i]);
			if (DIAG_X2[i] > DIAG_X1[i])
				band = in_pos.x >= x_start[i] && in_pos.x <= x_start[i] + span;
			else
				band = in_pos.x <= x_start[i] && in_pos.x >= x_start[i] - span;
			if (in_box && band)
				diag_hit = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_beat.pos       <= in_pos;
			out_beat.frame_hit <= frame_hit;
			out_beat.diag_hit  <= diag_hit;
		end
	end

endmodule

`default_nettype wire

//--- src/raster_scan.sv
// raster position source
`default_nettype none
`include "tunnel_macros.svh"

module raster_scan import tunnel_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	output pixel_pos_t pos,
	output logic       pos_valid,
	input  logic       pos_ready
);

	logic [9:0] x;
	logic [9:0] y;
	logic       last_col;
	logic       last_row;
	logic       advance;

	assign last_col = (x == 10'(`H_ACTIVE - 1));
	assign last_row = (y == 10'(`V_ACTIVE - 1));
	assign advance  = pos_valid && pos_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			x         <= '0;
			y         <= '0;
			pos_valid <= 1'b0;
		end else begin
			// always has a pixel to offer once out of reset
			pos_valid <= 1'b1;
			if (advance) begin
				if (last_col) begin
					x <= '0;
					y <= last_row ? '0 : y + 10'd1;
				end else begin
					x <= x + 10'd1;
				end
			end
		end
	end

	// counters only move on a transfer, so pos holds while stalled
	always_comb begin
		pos.x           = x;
		pos.y           = y;
		pos.line_end    = last_col;
		pos.frame_start = (x == '0) && (y == '0);
	end

endmodule

`default_nettype wire

//--- src/tunnel_pkg.sv
// tunnel pipeline beat types
`default_nettype none

package tunnel_pkg;

	// one raster position
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		// x is the last column
		logic       line_end;
		// first pixel of the frame
		logic       frame_start;
	} pixel_pos_t;

	// after the geometry stage
	typedef struct packed {
		pixel_pos_t pos;
		logic       frame_hit;
		logic       diag_hit;
	} geom_beat_t;

	// after the score stage
	typedef struct packed {
		geom_beat_t geom;
		logic       score_hit;
	} score_beat_t;

	// final pixel to the sink
	typedef struct packed {
		pixel_pos_t  pos;
		logic [23:0] color;
	} out_pixel_t;

endpackage

`default_nettype wire

//--- src/tunnel_macros.svh
// tunnel playfield layout
`ifndef TUNNEL_MACROS_SVH
`define TUNNEL_MACROS_SVH

`define H_ACTIVE 640
`define V_ACTIVE 480

`define COLOR_BG    24'h000000
`define COLOR_FRAME 24'h00FF00
`define COLOR_SCORE 24'h66FFFF

// nested rectangles given by upper-left corner and side lengths
`define FRAME_0_X 63
`define FRAME_0_Y 47
`define FRAME_0_W 514
`define FRAME_0_H 386
`define FRAME_1_X 132
`define FRAME_1_Y 99
`define FRAME_1_W 376
`define FRAME_1_H 283
`define FRAME_2_X 171
`define FRAME_2_Y 128
`define FRAME_2_W 297
`define FRAME_2_H 223
`define FRAME_3_X 197
`define FRAME_3_Y 148
`define FRAME_3_W 245
`define FRAME_3_H 185
`define FRAME_4_X 215
`define FRAME_4_Y 161
`define FRAME_4_W 209
`define FRAME_4_H 157
`define FRAME_5_X 229
`define FRAME_5_Y 171
`define FRAME_5_W 182
`define FRAME_5_H 137
`define FRAME_6_X 239
`define FRAME_6_Y 179
`define FRAME_6_W 162
`define FRAME_6_H 122
`define FRAME_7_X 247
`define FRAME_7_Y 185
`define FRAME_7_W 145
`define FRAME_7_H 109
`define FRAME_8_X 255
`define FRAME_8_Y 191
`define FRAME_8_W 130
`define FRAME_8_H 98

// corner diagonals run rightward when X2 > X1
`define DIAG_0_X1 63
`define DIAG_0_Y1 47
`define DIAG_0_X2 255
`define DIAG_0_Y2 191
`define DIAG_1_X1 384
`define DIAG_1_Y1 288
`define DIAG_1_X2 576
`define DIAG_1_Y2 432
`define DIAG_2_X1 255
`define DIAG_2_Y1 288
`define DIAG_2_X2 63
`define DIAG_2_Y2 432
`define DIAG_3_X1 576
`define DIAG_3_Y1 47
`define DIAG_3_X2 384
`define DIAG_3_Y2 191

// score digit cells
`define SCORE_L_X  64
`define SCORE_R_X  544
`define SCORE_Y    10
`define SCORE_CELL 32

`endif
